// File: logic/adapt_ctrl.sv
`default_nettype none

`include "ffe_config.svh"

module adapt_ctrl (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         cmd_req,
    input  wire logic [2:0]   cmd_op,
    output logic              cmd_ack,
    output ffe_pkg::tap_pos_t tap_pos,
    output logic              hold_sel,
    output logic              write_en,
    output logic              load_init,
    output logic              shift_left,
    output logic              shift_right
);

    ffe_pkg::ctrl_state_t state;
    ffe_pkg::cmd_op_t     op_q;
    logic                 last_tap;

    assign last_tap = (tap_pos == ffe_pkg::tap_pos_t'(`FFE_EST_DEPTH - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ffe_pkg::IDLE;
            op_q    <= ffe_pkg::CMD_NOP;
            tap_pos <= '0;
            cmd_ack <= 1'b0;
        end else begin
            case (state)
                ffe_pkg::IDLE: begin
                    tap_pos <= '0;
                    if (cmd_req) begin
                        op_q <= ffe_pkg::cmd_op_t'(cmd_op); // Decoded once, held to EXEC.
                        if (cmd_op == ffe_pkg::CMD_ADAPT) begin
                            state <= ffe_pkg::SWEEP_READ;
                        end else begin
                            state <= ffe_pkg::EXEC;
                        end
                    end
                end
                ffe_pkg::SWEEP_READ: begin
                    state <= ffe_pkg::SWEEP_WRITE;
                end
                ffe_pkg::SWEEP_WRITE: begin
                    if (last_tap) begin
                        tap_pos <= '0;
                        state   <= ffe_pkg::ACK;
                    end else begin
                        tap_pos <= tap_pos + 1'b1;
                        state   <= ffe_pkg::SWEEP_READ;
                    end
                end
                ffe_pkg::EXEC: begin
                    state <= ffe_pkg::ACK;
                end
                ffe_pkg::ACK: begin
                    // First cycle raises the ack, then wait for the host to drop req.
                    if (!cmd_ack) begin
                        cmd_ack <= 1'b1;
                    end else if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= ffe_pkg::IDLE;
                    end
                end
                default: begin
                    state <= ffe_pkg::IDLE;
                end
            endcase
        end
    end

    assign hold_sel = (state == ffe_pkg::SWEEP_WRITE);
    assign write_en = (state == ffe_pkg::SWEEP_WRITE); // Commits the second adjustment.

    always_comb begin
        load_init   = 1'b0;
        shift_left  = 1'b0;
        shift_right = 1'b0;
        if (state == ffe_pkg::EXEC) begin
            case (op_q)
                ffe_pkg::CMD_LOAD_INIT: begin
                    load_init = 1'b1;
                end
                ffe_pkg::CMD_SHIFT_LEFT: begin
                    shift_left = 1'b1;
                end
                ffe_pkg::CMD_SHIFT_RIGHT: begin
                    shift_right = 1'b1;
                end
                default: begin
                    // NOP and unused codes only pass through EXEC to ACK.
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/ffe_adapt_top.sv
`default_nettype none

`include "ffe_config.svh"

module ffe_adapt_top (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire ffe_pkg::sample_t est_bits [`FFE_EST_DEPTH],
    input  wire ffe_pkg::code_t   current_code,
    input  wire ffe_pkg::gain_t   gain,
    input  wire ffe_pkg::sample_t bit_level,
    input  wire ffe_pkg::tap_t    ffe_init [`FFE_EST_DEPTH],
    input  wire logic             cmd_req,
    input  wire logic [2:0]       cmd_op,
    output logic                  cmd_ack,
    output ffe_pkg::tap_t         ffe_est [`FFE_EST_DEPTH]
);

    ffe_pkg::tap_pos_t tap_pos;
    logic              hold_sel;
    logic              write_en;
    logic              load_init;
    logic              shift_left;
    logic              shift_right;
    ffe_pkg::acc_t     err;
    ffe_pkg::acc_t     acc_rd;
    ffe_pkg::acc_t     acc_new;

    adapt_ctrl i_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_req     (cmd_req),
        .cmd_op      (cmd_op),
        .cmd_ack     (cmd_ack),
        .tap_pos     (tap_pos),
        .hold_sel    (hold_sel),
        .write_en    (write_en),
        .load_init   (load_init),
        .shift_left  (shift_left),
        .shift_right (shift_right)
    );

    pam4_slicer i_slicer (
        .est_bits  (est_bits),
        .tap_pos   (tap_pos),
        .bit_level (bit_level),
        .err       (err)
    );

    tap_update i_update (
        .clk          (clk),
        .rst_n        (rst_n),
        .err          (err),
        .current_code (current_code),
        .gain         (gain),
        .hold_sel     (hold_sel),
        .acc_rd       (acc_rd),
        .acc_new      (acc_new)
    );

    tap_bank i_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .ffe_init    (ffe_init),
        .tap_pos     (tap_pos),
        .write_en    (write_en),
        .acc_new     (acc_new),
        .load_init   (load_init),
        .shift_left  (shift_left),
        .shift_right (shift_right),
        .acc_rd      (acc_rd),
        .ffe_est     (ffe_est)
    );

endmodule

`default_nettype wire

// File: logic/ffe_config.svh
`ifndef FFE_CONFIG_SVH
`define FFE_CONFIG_SVH

// Number of equalizer taps handled by the adaptation engine.
`define FFE_EST_DEPTH 10

`define FFE_SAMPLE_W 10

// Integer part of a tap, as seen at ffe_est.
`define FFE_TAP_W 10

// Fractional bits kept below the integer part of each accumulator.
`define FFE_FRAC_W 14

`define FFE_CODE_W 8

`define FFE_GAIN_W 4

`define FFE_POS_W 4

`endif

// File: logic/ffe_pkg.sv
`default_nettype none

`include "ffe_config.svh"

package ffe_pkg;

    typedef logic signed [`FFE_SAMPLE_W-1:0] sample_t;
    typedef logic signed [`FFE_TAP_W-1:0] tap_t;
    typedef logic signed [`FFE_TAP_W+`FFE_FRAC_W-1:0] acc_t; // Integer and fraction together.
    typedef logic signed [`FFE_CODE_W-1:0] code_t;
    typedef logic [`FFE_GAIN_W-1:0] gain_t;
    typedef logic [`FFE_POS_W-1:0] tap_pos_t;
    typedef logic [1:0] sym_idx_t;

    typedef enum logic [2:0] {
        CMD_NOP         = 3'd0,
        CMD_ADAPT       = 3'd1,
        CMD_SHIFT_RIGHT = 3'd2,
        CMD_SHIFT_LEFT  = 3'd3,
        CMD_LOAD_INIT   = 3'd4
    } cmd_op_t;

    typedef enum logic [2:0] {
        IDLE,
        SWEEP_READ,
        SWEEP_WRITE,
        EXEC,
        ACK
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/pam4_slicer.sv
`default_nettype none

`include "ffe_config.svh"

module pam4_slicer (
    input  wire ffe_pkg::sample_t  est_bits [`FFE_EST_DEPTH],
    input  wire ffe_pkg::tap_pos_t tap_pos,
    input  wire ffe_pkg::sample_t  bit_level,
    output ffe_pkg::acc_t          err
);

    // Thresholds and levels are in units of bit_level.
    localparam ffe_pkg::acc_t thresh_tab [3] = '{-24'sd2, 24'sd0, 24'sd2};
    localparam ffe_pkg::acc_t level_tab [4] = '{-24'sd3, -24'sd1, 24'sd1, 24'sd3};
    localparam ffe_pkg::acc_t weight_tab [4] = '{24'sd1, 24'sd3, 24'sd3, 24'sd1};

    ffe_pkg::sample_t sample;
    ffe_pkg::acc_t    sample_ext;
    ffe_pkg::acc_t    level_ext;
    ffe_pkg::acc_t    sliced;
    ffe_pkg::sym_idx_t sym_idx;

    always_comb begin
        sample     = est_bits[tap_pos];
        sample_ext = ffe_pkg::acc_t'(sample);
        level_ext  = ffe_pkg::acc_t'(bit_level);

        // The thresholds are ordered, so counting the ones exceeded gives the symbol.
        sym_idx = '0;
        for (int i = 0; i < 3; i++) begin
            if (sample_ext > level_ext * thresh_tab[i]) begin
                sym_idx = sym_idx + 2'd1;
            end
        end

        sliced = level_tab[sym_idx] * level_ext;
        err    = (sliced - sample_ext) * weight_tab[sym_idx]; // Inner symbols weigh three times.
    end

endmodule

`default_nettype wire

// File: logic/tap_bank.sv
`default_nettype none

`include "ffe_config.svh"

module tap_bank (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire ffe_pkg::tap_t     ffe_init [`FFE_EST_DEPTH],
    input  wire ffe_pkg::tap_pos_t tap_pos,
    input  wire logic              write_en,
    input  wire ffe_pkg::acc_t     acc_new,
    input  wire logic              load_init,
    input  wire logic              shift_left,
    input  wire logic              shift_right,
    output ffe_pkg::acc_t          acc_rd,
    output ffe_pkg::tap_t          ffe_est [`FFE_EST_DEPTH]
);

    ffe_pkg::acc_t acc_q [`FFE_EST_DEPTH];

    assign acc_rd = acc_q[tap_pos];

    // The controller never raises two of these strobes in the same cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FFE_EST_DEPTH; i++) begin
                acc_q[i] <= '0;
            end
        end else if (write_en) begin
            acc_q[tap_pos] <= acc_new;
        end else if (load_init) begin
            for (int i = 0; i < `FFE_EST_DEPTH; i++) begin
                acc_q[i] <= {ffe_init[i], {`FFE_FRAC_W{1'b0}}}; // Fraction starts at zero.
            end
        end else if (shift_right) begin
            for (int i = `FFE_EST_DEPTH - 1; i > 0; i--) begin
                acc_q[i] <= acc_q[i-1];
            end
            acc_q[0] <= '0;
        end else if (shift_left) begin
            for (int i = 0; i < `FFE_EST_DEPTH - 1; i++) begin
                acc_q[i] <= acc_q[i+1];
            end
            acc_q[`FFE_EST_DEPTH-1] <= '0;
        end
    end

    // Integer part only; the fraction stays internal.
    always_comb begin
        for (int i = 0; i < `FFE_EST_DEPTH; i++) begin
            ffe_est[i] = ffe_pkg::tap_t'(acc_q[i] >>> `FFE_FRAC_W);
        end
    end

endmodule

`default_nettype wire

// File: logic/tap_update.sv
`default_nettype none

module tap_update (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire ffe_pkg::acc_t  err,
    input  wire ffe_pkg::code_t current_code,
    input  wire ffe_pkg::gain_t gain,
    input  wire logic           hold_sel,
    input  wire ffe_pkg::acc_t  acc_rd,
    output ffe_pkg::acc_t       acc_new
);

    ffe_pkg::acc_t code_ext;
    ffe_pkg::acc_t adjust;
    ffe_pkg::acc_t base;
    ffe_pkg::acc_t base_q;

    assign code_ext = ffe_pkg::acc_t'(current_code);

    // Wraps at the accumulator width, like the bank itself.
    assign adjust = (code_ext * err) <<< gain;

    assign base    = hold_sel ? base_q : acc_rd; // Write cycle builds on the read-cycle sum.
    assign acc_new = base + adjust;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_q <= '0;
        end else if (!hold_sel) begin
            base_q <= acc_new;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/ffe_pkg.sv
logic/pam4_slicer.sv
logic/tap_update.sv
logic/tap_bank.sv
logic/adapt_ctrl.sv
logic/ffe_adapt_top.sv
verification/ffe_adapt_props.sv
verification/ffe_adapt_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module ffe_adapt_tb -o ffe_adapt_sim \
    && ./obj_dir/ffe_adapt_sim | tee /dev/stderr | grep -qx '>>> PASS' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verification/ffe_adapt_props.sv
`default_nettype none

module ffe_adapt_props (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic cmd_req,
    input wire logic cmd_ack,
    input wire logic write_en,
    input wire logic load_init,
    input wire logic shift_left,
    input wire logic shift_right
);

    // The edge that set the ack must have seen the request.
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> $past(cmd_req))
        else $error("cmd_ack rose while cmd_req was low");

    // The ack is held for as long as the host keeps its request up.
    ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_ack && cmd_req |=> cmd_ack)
        else $error("cmd_ack fell while cmd_req was still high");

    ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_ack && !cmd_req |=> !cmd_ack)
        else $error("cmd_ack did not fall the cycle after cmd_req went low");

    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({write_en, load_init, shift_left, shift_right}))
        else $error("more than one tap bank strobe was high");

endmodule

`default_nettype wire

// File: verification/ffe_adapt_tb.sv
`default_nettype none

`include "ffe_config.svh"

module ffe_adapt_tb;

    localparam int NUM_CMDS       = 60;
    localparam int CYCLES_PER_CMD = 40;
    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 10;
    localparam int WATCHDOG_TIME  = (RESET_CYCLES + NUM_CMDS * CYCLES_PER_CMD) * CLK_PERIOD;

    // Slicer tables in units of bit_level.
    localparam int thresh_ref [3] = '{-2, 0, 2};
    localparam int level_ref [4]  = '{-3, -1, 1, 3};
    localparam int weight_ref [4] = '{1, 3, 3, 1};

    logic             clk;
    logic             rst_n;
    ffe_pkg::sample_t est_bits [`FFE_EST_DEPTH];
    ffe_pkg::code_t   current_code;
    ffe_pkg::gain_t   gain;
    ffe_pkg::sample_t bit_level;
    ffe_pkg::tap_t    ffe_init [`FFE_EST_DEPTH];
    logic             cmd_req;
    logic [2:0]       cmd_op;
    logic             cmd_ack;
    ffe_pkg::tap_t    ffe_est [`FFE_EST_DEPTH];

    ffe_pkg::acc_t    model_acc [`FFE_EST_DEPTH];
    logic [31:0]      rng_state;
    int               errors;
    int               checks;

    ffe_adapt_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .est_bits     (est_bits),
        .current_code (current_code),
        .gain         (gain),
        .bit_level    (bit_level),
        .ffe_init     (ffe_init),
        .cmd_req      (cmd_req),
        .cmd_op       (cmd_op),
        .cmd_ack      (cmd_ack),
        .ffe_est      (ffe_est)
    );

    bind ffe_adapt_top ffe_adapt_props i_props (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_req     (cmd_req),
        .cmd_ack     (cmd_ack),
        .write_en    (write_en),
        .load_init   (load_init),
        .shift_left  (shift_left),
        .shift_right (shift_right)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic drive_random_inputs();
        int          bl;
        int          span;
        int          s;
        logic [31:0] r;
        bl           = 1 + int'(next_rand() % 63);
        bit_level    = ffe_pkg::sample_t'(bl);
        gain         = ffe_pkg::gain_t'(next_rand() % 4);
        current_code = ffe_pkg::code_t'(next_rand());
        span         = 8 * bl + 1;
        for (int i = 0; i < `FFE_EST_DEPTH; i++) begin
            r = next_rand();
            if (r[0]) begin
                est_bits[i] = ffe_pkg::sample_t'(r[31:22]); // Full range, mostly outer levels.
            end else begin
                s = int'(r % span) - 4 * bl; // Near the thresholds, so every symbol shows up.
                est_bits[i] = ffe_pkg::sample_t'(s);
            end
            ffe_init[i] = ffe_pkg::tap_t'(next_rand() >> 22);
        end
    endtask

    task automatic model_load();
        for (int i = 0; i < `FFE_EST_DEPTH; i++) begin
            model_acc[i] = ffe_pkg::acc_t'(int'(ffe_init[i]) * (1 << `FFE_FRAC_W));
        end
    endtask

    task automatic model_shift(input logic to_right);
        if (to_right) begin
            for (int i = `FFE_EST_DEPTH - 1; i > 0; i--) begin
                model_acc[i] = model_acc[i-1];
            end
            model_acc[0] = '0;
        end else begin
            for (int i = 0; i < `FFE_EST_DEPTH - 1; i++) begin
                model_acc[i] = model_acc[i+1];
            end
            model_acc[`FFE_EST_DEPTH-1] = '0;
        end
    endtask

    task automatic model_adapt();
        int            bl;
        int            s;
        int            sym;
        int            err;
        longint        adj;
        ffe_pkg::acc_t adj24;
        bl = int'(bit_level);
        for (int i = 0; i < `FFE_EST_DEPTH; i++) begin
            s   = int'(est_bits[i]);
            sym = 0;
            for (int t = 0; t < 3; t++) begin
                if (s > thresh_ref[t] * bl) begin
                    sym++;
                end
            end
            err   = (level_ref[sym] * bl - s) * weight_ref[sym];
            adj   = longint'(int'(current_code)) * longint'(err);
            adj   = adj << gain;
            adj24 = ffe_pkg::acc_t'(adj);
            model_acc[i] = model_acc[i] + adj24 + adj24; // Two equal steps per sweep.
        end
    endtask

    task automatic check_taps();
        ffe_pkg::tap_t exp_tap;
        for (int i = 0; i < `FFE_EST_DEPTH; i++) begin
            exp_tap = model_acc[i][`FFE_TAP_W+`FFE_FRAC_W-1:`FFE_FRAC_W];
            checks++;
            assert (ffe_est[i] === exp_tap) else begin
                errors++;
                $display("mismatch at %0t: ffe_est[%0d] is %0d, expected %0d",
                         $time, i, ffe_est[i], exp_tap);
            end
        end
    endtask

    task automatic run_command(input logic [2:0] op);
        int waited;
        int expect_lat;
        int hold;
        drive_random_inputs();
        cmd_op     = op;
        cmd_req    = 1'b1;
        expect_lat = (op == ffe_pkg::CMD_ADAPT) ? 2 * `FFE_EST_DEPTH + 1 : 2;
        waited     = 0;
        while (cmd_ack !== 1'b1 && waited < CYCLES_PER_CMD) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (cmd_ack === 1'b1) else begin
            errors++;
            $display("handshake stalled at %0t: no cmd_ack for command %0d", $time, op);
            cmd_req = 1'b0;
            return;
        end
        checks++;
        assert (waited == expect_lat + 1) else begin
            errors++;
            $display("mismatch at %0t: ack latency for op %0d is %0d, expected %0d",
                     $time, op, waited - 1, expect_lat);
        end
        case (op)
            ffe_pkg::CMD_LOAD_INIT:   model_load();
            ffe_pkg::CMD_SHIFT_LEFT:  model_shift(1'b0);
            ffe_pkg::CMD_SHIFT_RIGHT: model_shift(1'b1);
            ffe_pkg::CMD_ADAPT:       model_adapt();
            default:                  ;
        endcase
        check_taps();
        hold = int'(next_rand() % 3); // The host may sit on an ack for a while.
        repeat (hold) begin
            @(negedge clk);
            checks++;
            assert (cmd_ack === 1'b1) else begin
                errors++;
                $display("mismatch at %0t: cmd_ack is %0b while cmd_req is high, expected 1",
                         $time, cmd_ack);
            end
        end
        cmd_req = 1'b0;
        @(negedge clk);
        checks++;
        assert (cmd_ack === 1'b0) else begin
            errors++;
            $display("mismatch at %0t: cmd_ack is %0b after cmd_req dropped, expected 0",
                     $time, cmd_ack);
        end
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired at %0t, the command sequence never finished", $time);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [2:0]  op;
        logic [31:0] pick;
        clk          = 1'b0;
        rst_n        = 1'b0;
        cmd_req      = 1'b0;
        cmd_op       = 3'd0;
        current_code = '0;
        gain         = '0;
        bit_level    = ffe_pkg::sample_t'(1);
        errors       = 0;
        checks       = 0;
        rng_state    = 32'h2c7d385b;
        for (int i = 0; i < `FFE_EST_DEPTH; i++) begin
            est_bits[i]  = '0;
            ffe_init[i]  = '0;
            model_acc[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        checks++;
        assert (cmd_ack === 1'b0) else begin
            errors++;
            $display("mismatch at %0t: cmd_ack is %0b after reset, expected 0", $time, cmd_ack);
        end
        check_taps();
        run_command(ffe_pkg::CMD_LOAD_INIT);
        for (int n = 1; n < NUM_CMDS; n++) begin
            pick = next_rand() % 10;
            case (pick)
                32'd0:   op = ffe_pkg::CMD_LOAD_INIT;
                32'd1:   op = ffe_pkg::CMD_SHIFT_LEFT;
                32'd2:   op = ffe_pkg::CMD_SHIFT_RIGHT;
                32'd7:   op = ffe_pkg::CMD_NOP;
                32'd8,
                32'd9:   op = 3'd5 + 3'(next_rand() % 3); // Unused codes.
                default: op = ffe_pkg::CMD_ADAPT;
            endcase
            run_command(op);
            repeat (int'(next_rand() % 3)) @(negedge clk);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
